/* include/rtc_ctrl_settings.svh */
`ifndef RTC_CTRL_SETTINGS_SVH
`define RTC_CTRL_SETTINGS_SVH

////////////////////////////////////////////////////////////
// Chip side bus
////////////////////////////////////////////////////////////

// Register address and data byte share the ad pins
`define RTC_ADDR_W 8
`define RTC_DATA_W 8

// Clocks spent in each of the address and data phases
`define RTC_PHASE_CYCLES 4

////////////////////////////////////////////////////////////
// Host side bus
////////////////////////////////////////////////////////////

`define APB_ADDR_W 4
`define APB_DATA_W 32

`endif

/* src/rtc_bus_pkg.sv */
package rtc_bus_pkg;

  ////////////////////////////////////////////////////////////
  // Chip bus cycle
  ////////////////////////////////////////////////////////////

  // One multiplexed write cycle on the chip pins.
  //   idle        pins released, waiting for a request
  //   addr_phase  cs_n low, as high, ad holds the register address
  //   data_phase  cs_n low, wr_n low, ad holds the data byte
  //   recover     pins released again, end of cycle reported
  typedef enum logic [1:0] {
    idle       = 2'd0,
    addr_phase = 2'd1,
    data_phase = 2'd2,
    recover    = 2'd3
  } bus_state_t;

endpackage

/* src/rtc_reg_pkg.sv */
`include "rtc_ctrl_settings.svh"

package rtc_reg_pkg;

  ////////////////////////////////////////////////////////////
  // Host register map
  ////////////////////////////////////////////////////////////

  // reg_write   [15:8] chip address, [7:0] data, write starts a transfer
  // reg_status  [0] busy, [1] done (sticky, cleared by a read)
  typedef enum logic [`APB_ADDR_W-1:0] {
    reg_write  = 4'h0,
    reg_status = 4'h4
  } apb_reg_t;

  ////////////////////////////////////////////////////////////
  // Write sequencer
  ////////////////////////////////////////////////////////////

  typedef enum logic [2:0] {
    seq_idle    = 3'd0,
    seq_write   = 3'd1,
    seq_decide  = 3'd2,
    seq_command = 3'd3,
    seq_finish  = 3'd4
  } seq_state_t;

  // Transfer commands, sent as both address and data of a cycle
  typedef enum logic [`RTC_DATA_W-1:0] {
    cmd_time_xfer  = 8'hF0,
    cmd_timer_xfer = 8'hF2
  } rtc_cmd_t;

endpackage

/* src/rtc_apb_slave.sv */
`include "rtc_ctrl_settings.svh"

module rtc_apb_slave (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`APB_ADDR_W-1:0] paddr,
  input  logic [`APB_DATA_W-1:0] pwdata,
  input  logic                   complete,
  output logic [`APB_DATA_W-1:0] prdata,
  output logic                   pslverr,
  output logic                   start,
  output logic [`RTC_ADDR_W-1:0] wr_addr,
  output logic [`RTC_DATA_W-1:0] wr_data
);
  import rtc_reg_pkg::*;

  logic busy;
  logic done;
  logic access;
  logic known_offset;
  logic write_hit;
  logic accept;
  logic status_read;

  ////////////////////////////////////////////////////////////
  // Access decode
  ////////////////////////////////////////////////////////////

  // Zero wait states, so every transfer ends in its access phase
  assign access       = psel && penable;
  assign known_offset = (paddr == reg_write) || (paddr == reg_status);
  assign write_hit    = access && pwrite && (paddr == reg_write);
  assign accept       = write_hit && !busy;
  assign status_read  = access && !pwrite && (paddr == reg_status);

  // Only one request in flight, a second one is refused
  assign pslverr = access && (!known_offset || (write_hit && busy));

  always_comb begin
    case (paddr)
      reg_write:  prdata = `APB_DATA_W'({wr_addr, wr_data});
      reg_status: prdata = `APB_DATA_W'({done, busy});
      default:    prdata = '0;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Request and flags
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy <= 1'b0;
      done <= 1'b0;
    end else begin
      if (accept) begin
        busy <= 1'b1;
      end else if (complete) begin
        busy <= 1'b0;
      end

      // A completion in the same cycle as a status read must survive
      if (status_read) begin
        done <= 1'b0;
      end
      if (complete) begin
        done <= 1'b1;
      end
    end
  end

  // Held stable for the sequencer while busy
  always_ff @(posedge clk) begin
    if (accept) begin
      wr_addr <= pwdata[15:8];
      wr_data <= pwdata[7:0];
    end
  end

  assign start = busy;

endmodule

/* src/rtc_write_sequencer.sv */
`include "rtc_ctrl_settings.svh"

module rtc_write_sequencer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  logic [`RTC_ADDR_W-1:0] wr_addr,
  input  logic [`RTC_DATA_W-1:0] wr_data,
  input  logic                   cycle_done,
  output logic                   cycle_req,
  output logic [`RTC_ADDR_W-1:0] cycle_addr,
  output logic [`RTC_DATA_W-1:0] cycle_data,
  output logic                   complete
);
  import rtc_reg_pkg::*;

  // Chip address ranges that need a transfer command afterwards
  localparam logic [`RTC_ADDR_W-1:0] TIME_LO  = 8'h21;
  localparam logic [`RTC_ADDR_W-1:0] TIME_HI  = 8'h26;
  localparam logic [`RTC_ADDR_W-1:0] TIMER_LO = 8'h41;
  localparam logic [`RTC_ADDR_W-1:0] TIMER_HI = 8'h43;

  seq_state_t state;
  logic       in_time_range;
  logic       in_timer_range;
  rtc_cmd_t   cmd_opcode;

  ////////////////////////////////////////////////////////////
  // Address classification
  ////////////////////////////////////////////////////////////

  // cycle_addr still holds the data write address in seq_decide
  assign in_time_range  = (cycle_addr >= TIME_LO) && (cycle_addr <= TIME_HI);
  assign in_timer_range = (cycle_addr >= TIMER_LO) && (cycle_addr <= TIMER_HI);
  assign cmd_opcode     = in_timer_range ? cmd_timer_xfer : cmd_time_xfer;

  ////////////////////////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= seq_idle;
      cycle_req <= 1'b0;
    end else if (!start) begin
      // Request withdrawn, abandon whatever was in progress
      state     <= seq_idle;
      cycle_req <= 1'b0;
    end else begin
      case (state)
        seq_idle: begin
          state     <= seq_write;
          cycle_req <= 1'b1;
        end
        seq_write: begin
          if (cycle_done) begin
            state     <= seq_decide;
            cycle_req <= 1'b0;
          end
        end
        seq_decide: begin
          if (in_time_range || in_timer_range) begin
            state <= seq_command;
          end else begin
            state <= seq_finish;
          end
        end
        seq_command: begin
          // Opcode loaded on entry, request raised one clock later
          if (cycle_done) begin
            state     <= seq_finish;
            cycle_req <= 1'b0;
          end else begin
            cycle_req <= 1'b1;
          end
        end
        seq_finish: begin
          state <= seq_idle;
        end
        default: begin
          state     <= seq_idle;
          cycle_req <= 1'b0;
        end
      endcase
    end
  end

  // Cycle payload, data write first and then the command opcode
  always_ff @(posedge clk) begin
    if (state == seq_idle && start) begin
      cycle_addr <= wr_addr;
      cycle_data <= wr_data;
    end else if (state == seq_decide && (in_time_range || in_timer_range)) begin
      cycle_addr <= `RTC_ADDR_W'(cmd_opcode);
      cycle_data <= `RTC_DATA_W'(cmd_opcode);
    end
  end

  assign complete = (state == seq_finish);

endmodule

/* src/rtc_bus_cycle.sv */
`include "rtc_ctrl_settings.svh"

module rtc_bus_cycle (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   cycle_req,
  input  logic [`RTC_ADDR_W-1:0] cycle_addr,
  input  logic [`RTC_DATA_W-1:0] cycle_data,
  output logic                   cs_n,
  output logic                   as,
  output logic                   wr_n,
  output logic [`RTC_ADDR_W-1:0] ad,
  output logic                   cycle_done
);
  import rtc_bus_pkg::*;

  localparam int PHASE_W = $clog2(`RTC_PHASE_CYCLES + 1);
  localparam logic [PHASE_W-1:0] PHASE_LAST = PHASE_W'(`RTC_PHASE_CYCLES - 1);

  bus_state_t         state;
  logic [PHASE_W-1:0] phase_cnt;
  logic               phase_end;

  assign phase_end = (phase_cnt == PHASE_LAST);

  ////////////////////////////////////////////////////////////
  // Cycle FSM and registered pins
  ////////////////////////////////////////////////////////////

  // Pins change on state transitions so they never glitch
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state      <= idle;
      phase_cnt  <= '0;
      cs_n       <= 1'b1;
      as         <= 1'b0;
      wr_n       <= 1'b1;
      ad         <= '0;
      cycle_done <= 1'b0;
    end else begin
      cycle_done <= 1'b0;

      case (state)
        idle: begin
          if (cycle_req) begin
            state     <= addr_phase;
            phase_cnt <= '0;
            cs_n      <= 1'b0;
            as        <= 1'b1;
            ad        <= cycle_addr;
          end
        end
        addr_phase: begin
          if (phase_end) begin
            // Falling as latches the address in the chip
            state     <= data_phase;
            phase_cnt <= '0;
            as        <= 1'b0;
            wr_n      <= 1'b0;
            ad        <= `RTC_ADDR_W'(cycle_data);
          end else begin
            phase_cnt <= phase_cnt + PHASE_W'(1);
          end
        end
        data_phase: begin
          if (phase_end) begin
            // Rising wr_n writes the byte, then release the bus
            state      <= recover;
            phase_cnt  <= '0;
            cs_n       <= 1'b1;
            wr_n       <= 1'b1;
            ad         <= '0;
            cycle_done <= 1'b1;
          end else begin
            phase_cnt <= phase_cnt + PHASE_W'(1);
          end
        end
        recover: begin
          state <= idle;
        end
        default: begin
          state <= idle;
        end
      endcase
    end
  end

endmodule

/* src/rtc_ctrl.sv */
`include "rtc_ctrl_settings.svh"

module rtc_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   psel,
  input  logic                   penable,
  input  logic                   pwrite,
  input  logic [`APB_ADDR_W-1:0] paddr,
  input  logic [`APB_DATA_W-1:0] pwdata,
  output logic [`APB_DATA_W-1:0] prdata,
  output logic                   pready,
  output logic                   pslverr,
  output logic                   cs_n,
  output logic                   as,
  output logic                   wr_n,
  output logic [`RTC_ADDR_W-1:0] ad
);

  // Slave to sequencer
  logic                   start;
  logic                   complete;
  logic [`RTC_ADDR_W-1:0] wr_addr;
  logic [`RTC_DATA_W-1:0] wr_data;

  // Sequencer to bus cycle
  logic                   cycle_req;
  logic                   cycle_done;
  logic [`RTC_ADDR_W-1:0] cycle_addr;
  logic [`RTC_DATA_W-1:0] cycle_data;

  // No wait states on the host bus
  assign pready = 1'b1;

  rtc_apb_slave u_apb_slave (
    .clk      (clk),
    .rst_n    (rst_n),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .paddr    (paddr),
    .pwdata   (pwdata),
    .complete (complete),
    .prdata   (prdata),
    .pslverr  (pslverr),
    .start    (start),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  rtc_write_sequencer u_write_sequencer (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .cycle_done (cycle_done),
    .cycle_req  (cycle_req),
    .cycle_addr (cycle_addr),
    .cycle_data (cycle_data),
    .complete   (complete)
  );

  rtc_bus_cycle u_bus_cycle (
    .clk        (clk),
    .rst_n      (rst_n),
    .cycle_req  (cycle_req),
    .cycle_addr (cycle_addr),
    .cycle_data (cycle_data),
    .cs_n       (cs_n),
    .as         (as),
    .wr_n       (wr_n),
    .ad         (ad),
    .cycle_done (cycle_done)
  );

endmodule

/* verification/rtc_ctrl_tb.sv */
`include "rtc_ctrl_settings.svh"

module rtc_ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import rtc_reg_pkg::*;

  // Worst case write is two chip cycles plus sequencer overhead
  localparam int BUS_CYCLE_CLKS   = 2 * `RTC_PHASE_CYCLES + 1;
  localparam int WORST_WRITE_CLKS = 2 * BUS_CYCLE_CLKS + 4;
  localparam int WRITE_BUDGET     = WORST_WRITE_CLKS + 40;
  localparam int MAX_WRITES       = 60;
  localparam int TIMEOUT_NS       = (8 + MAX_WRITES * WRITE_BUDGET) * 100;

  logic                   clk = 1'b0;
  logic                   rst_n;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [`APB_ADDR_W-1:0] paddr;
  logic [`APB_DATA_W-1:0] pwdata;
  logic [`APB_DATA_W-1:0] prdata;
  logic                   pready;
  logic                   pslverr;
  logic                   cs_n;
  logic                   as;
  logic                   wr_n;
  logic [`RTC_ADDR_W-1:0] ad;

  // Chip cycles as {address, data}
  logic [15:0] exp_q[$];
  logic [15:0] rec_q[$];

  logic [`RTC_ADDR_W-1:0] cap_addr;
  logic [`RTC_DATA_W-1:0] cap_data;
  logic                   wr_n_prev = 1'b1;

  rtc_ctrl UUT (
    .clk     (clk),
    .rst_n   (rst_n),
    .psel    (psel),
    .penable (penable),
    .pwrite  (pwrite),
    .paddr   (paddr),
    .pwdata  (pwdata),
    .prdata  (prdata),
    .pready  (pready),
    .pslverr (pslverr),
    .cs_n    (cs_n),
    .as      (as),
    .wr_n    (wr_n),
    .ad      (ad)
  );

  always #50 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      report_failure($sformatf("mismatch %s: got 0x%0h, expected 0x%0h",
                               name, actual, expected));
    end
  endtask

  // Expected chip cycles for one posted write with the command pair in [31:16]
  function automatic logic [31:0] expected_pairs(input logic [7:0] addr,
                                                 input logic [7:0] data,
                                                 output int count);
    logic [7:0] cmd;
    cmd = 8'h00;
    count = 1;
    if (addr >= 8'h21 && addr <= 8'h26) begin
      cmd = 8'hF0;
      count = 2;
    end else if (addr >= 8'h41 && addr <= 8'h43) begin
      cmd = 8'hF2;
      count = 2;
    end
    expected_pairs = {cmd, cmd, addr, data};
  endfunction

  ////////////////////////////////////////////////////////////
  // APB host tasks
  ////////////////////////////////////////////////////////////

  // Entered and left 10 ns after a rising edge
  task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                           output logic err);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b1;
    paddr = addr;
    pwdata = data;
    @(posedge clk);
    #10;
    penable = 1'b1;
    @(negedge clk);
    err = pslverr;
    check_value("pready", 32'(pready), 32'h1);
    @(posedge clk);
    #10;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = addr;
    @(posedge clk);
    #10;
    penable = 1'b1;
    @(negedge clk);
    data = prdata;
    check_value("pslverr on read", 32'(pslverr), 32'h0);
    @(posedge clk);
    #10;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic post_write(input logic [7:0] addr, input logic [7:0] data);
    logic [31:0] pairs;
    logic [31:0] status;
    int          count;
    logic        err;
    pairs = expected_pairs(addr, data, count);
    exp_q.push_back(pairs[15:0]);
    if (count > 1) begin
      exp_q.push_back(pairs[31:16]);
    end
    apb_write(reg_write, {16'h0, addr, data}, err);
    check_value("pslverr", 32'(err), 32'h0);
    apb_read(reg_status, status);
    check_value("status after write", status, 32'h1);
  endtask

  // Poll until done, then done must read back cleared
  task automatic wait_done();
    logic [31:0] status;
    status = 32'h0;
    while (status[1] == 1'b0) begin
      apb_read(reg_status, status);
    end
    check_value("status at done", status, 32'h2);
    apb_read(reg_status, status);
    check_value("status after done read", status, 32'h0);
    check_value("chip cycles still expected", 32'(exp_q.size()), 32'h0);
  endtask

  task automatic write_and_finish(input logic [7:0] addr, input logic [7:0] data);
    post_write(addr, data);
    wait_done();
  endtask

  ////////////////////////////////////////////////////////////
  // Chip bus monitor and compare
  ////////////////////////////////////////////////////////////

  // Pins are registered, so the falling edge sees them settled
  always @(negedge clk) begin
    if (rst_n) begin
      // A chip cycle is active while as is high or wr_n is low
      if (as || !wr_n) begin
        check_value("cs_n during cycle", 32'(cs_n), 32'h0);
      end else begin
        check_value("cs_n while idle", 32'(cs_n), 32'h1);
        check_value("ad while idle", 32'(ad), 32'h0);
      end
      if (as) begin
        check_value("wr_n in address phase", 32'(wr_n), 32'h1);
        cap_addr = ad;
      end
      if (!wr_n) begin
        cap_data = ad;
      end
      if (wr_n && !wr_n_prev) begin
        rec_q.push_back({cap_addr, cap_data});
      end
      wr_n_prev = wr_n;
    end
  end

  initial begin
    logic [15:0] got;
    logic [15:0] want;
    forever begin
      @(posedge clk);
      while (rec_q.size() > 0) begin
        got = rec_q.pop_front();
        if (exp_q.size() == 0) begin
          report_failure("A chip write cycle appeared with no write expecting it");
        end else begin
          want = exp_q.pop_front();
          check_value("cycle address", 32'(got[15:8]), 32'(want[15:8]));
          check_value("cycle data", 32'(got[7:0]), 32'(want[7:0]));
        end
      end
    end
  end

  initial begin
    #(TIMEOUT_NS);
    report_failure($sformatf("Timeout, the writes did not finish within %0d ns",
                             TIMEOUT_NS));
  end

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////

  initial begin
    int          idx;
    int          kind;
    logic [7:0]  addr;
    logic        err;
    logic [31:0] status;
    void'($urandom(32'he07bda23));
    rst_n = 1'b0;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    repeat (8) @(posedge clk);
    #10;
    rst_n = 1'b1;
    @(posedge clk);
    #10;

    apb_read(reg_status, status);
    check_value("status after reset", status, 32'h0);

    // Plain addresses including the range edges
    write_and_finish(8'h10, 8'h5A);
    write_and_finish(8'h20, 8'(($urandom)));
    write_and_finish(8'h27, 8'(($urandom)));
    write_and_finish(8'h40, 8'(($urandom)));
    write_and_finish(8'h44, 8'(($urandom)));

    for (idx = 8'h21; idx <= 8'h26; idx++) begin
      write_and_finish(8'(idx), 8'($urandom));
    end
    for (idx = 8'h41; idx <= 8'h43; idx++) begin
      write_and_finish(8'(idx), 8'($urandom));
    end

    // Second write while busy is refused
    post_write(8'h24, 8'h3C);
    apb_write(reg_write, {16'h0, 8'h11, 8'h22}, err);
    check_value("pslverr on busy write", 32'(err), 32'h1);
    wait_done();

    apb_write(4'h8, 32'h0000_1234, err);
    check_value("pslverr on unknown offset", 32'(err), 32'h1);

    for (idx = 0; idx < 30; idx++) begin
      kind = int'($urandom % 3);
      case (kind)
        0: begin
          addr = 8'h21;
          while ((addr >= 8'h21 && addr <= 8'h26) ||
                 (addr >= 8'h41 && addr <= 8'h43)) begin
            addr = 8'($urandom);
          end
        end
        1: addr = 8'h21 + 8'($urandom % 6);
        default: addr = 8'h41 + 8'($urandom % 3);
      endcase
      write_and_finish(addr, 8'($urandom));
    end

    // Leave room for any stray cycle to show up
    repeat (2 * BUS_CYCLE_CLKS) @(posedge clk);
    $display("Testbench passed");
    $finish;
  end

endmodule

/* rtc_ctrl.f */
+incdir+include
src/rtc_bus_pkg.sv
src/rtc_reg_pkg.sv
src/rtc_apb_slave.sv
src/rtc_write_sequencer.sv
src/rtc_bus_cycle.sv
src/rtc_ctrl.sv
verification/rtc_ctrl_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the rtc_ctrl testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
  --top-module rtc_ctrl_tb -f rtc_ctrl.f -o rtc_ctrl_sim

# The simulator exit status is ignored, the printed result decides
sim_out=$(./obj_dir/rtc_ctrl_sim) || true
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -q "Testbench passed"
